// ==== verilog/tackPkg.sv ====
package tackPkg;

    ////////////////////////////////////////////////////////////
    // Counter widths
    ////////////////////////////////////////////////////////////

    // ROM setup counter, longest count is 11 plus hold of 4
    localparam int ROM_CNT_WIDTH = 4;
    // Timeout counter
    localparam int TIMEOUT_WIDTH = 8;
    // Termination sequence state
    localparam int SEQ_WIDTH = 2;

    ////////////////////////////////////////////////////////////
    // Cycle lengths in CLK80 clocks
    ////////////////////////////////////////////////////////////

    // ROM enable held low after the ROM request
    localparam int ROM_HOLD_CYCLES = 4;
    // Unclaimed transfer ends after this many clocks
    localparam int TIMEOUT_CYCLES = 249;
    // Acknowledge driven low this long
    localparam int ACK_ASSERT_CYCLES = 2;
    // Autovector and RTC cycles have no data, keep them short
    localparam int AV_DELAY_CYCLES = 2;

    // Same lengths sized to their counters
    localparam logic [ROM_CNT_WIDTH-1:0] ROM_HOLD_CNT = ROM_CNT_WIDTH'(ROM_HOLD_CYCLES);
    localparam logic [TIMEOUT_WIDTH-1:0] TIMEOUT_LAST = TIMEOUT_WIDTH'(TIMEOUT_CYCLES);

    // Sequencer states
    // Idle, then assert states, then one negate state
    localparam logic [SEQ_WIDTH-1:0] SEQ_IDLE = '0;
    localparam logic [SEQ_WIDTH-1:0] SEQ_LAST_ASSERT = SEQ_WIDTH'(ACK_ASSERT_CYCLES);
    localparam logic [SEQ_WIDTH-1:0] SEQ_NEGATE = SEQ_WIDTH'(ACK_ASSERT_CYCLES + 1);

    // ROM strap to setup delay
    // 00 is the slowest ROM, 11 the fastest
    function automatic logic [ROM_CNT_WIDTH-1:0] romDelayTable(input logic [1:0] strap);
        case (strap)
            2'b00:   return ROM_CNT_WIDTH'(11);
            2'b01:   return ROM_CNT_WIDTH'(8);
            2'b10:   return ROM_CNT_WIDTH'(5);
            default: return ROM_CNT_WIDTH'(2);
        endcase
    endfunction

endpackage

// ==== verilog/romAckTimer.sv ====
`timescale 1ns/1ps

module romAckTimer (
    input  logic       CLK80,
    input  logic       DELAYED_TACK_RST,
    input  logic       clk40,
    input  logic       tsN,
    input  logic       romSel,
    input  logic [1:0] romDelay,
    output logic       romEnN,
    output logic       romReq
);

    import tackPkg::*;

    // Start of a ROM transfer
    logic romStart;
    // Clocks since the start, zero when idle
    logic [ROM_CNT_WIDTH-1:0] romCnt;
    // Setup delay from the strap
    logic [ROM_CNT_WIDTH-1:0] romDelayClks;
    // Count at which the ROM is released
    logic [ROM_CNT_WIDTH-1:0] romReleaseCnt;

    ////////////////////////////////////////////////////////////
    // ROM cycle decode
    ////////////////////////////////////////////////////////////

    // TS is only valid in the high clk40 phase
    assign romStart = !tsN && clk40 && romSel;

    // Strap is static, no need to latch it
    assign romDelayClks = romDelayTable(romDelay);
    // Longest case is 11 plus 4, fits the counter
    assign romReleaseCnt = romDelayClks + ROM_HOLD_CNT;

    ////////////////////////////////////////////////////////////
    // Setup counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            romCnt <= '0;
        end else if (romCnt == '0) begin
            // Idle until a ROM start
            if (romStart) begin
                romCnt <= romCnt + 1'b1;
            end
        end else if (romCnt == romReleaseCnt) begin
            romCnt <= '0;
        end else begin
            romCnt <= romCnt + 1'b1;
        end
    end

    // ROM enable and termination request
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            romEnN <= 1'b1;
            romReq <= 1'b0;
        end else begin
            // One clock wide, delay never reaches zero
            romReq <= (romCnt == romDelayClks);
            // Enable the ROM one clock into the cycle
            if (romCnt == ROM_CNT_WIDTH'(1)) begin
                romEnN <= 1'b0;
            end else if (romCnt == romReleaseCnt) begin
                // Hold past the acknowledge for data hold time
                romEnN <= 1'b1;
            end
        end
    end

    // Request only while the ROM is driving
    romReqInsideEnable: assert property (
        @(posedge CLK80) disable iff (DELAYED_TACK_RST)
        romReq |-> !romEnN
    ) else $error("romReq high while romEnN is high");

endmodule

// ==== verilog/ciaAck.sv ====
`timescale 1ns/1ps

module ciaAck (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic clk40,
    input  logic ciaSel,
    input  logic ciaClk,
    output logic ciaReq
);

    // CIA handshake states
    typedef enum logic [1:0] {
        CIA_IDLE,
        CIA_WAIT_HIGH,
        CIA_WAIT_FALL,
        CIA_WAIT_DESEL
    } ciaStateT;

    ciaStateT ciaState;

    // Two flop syncs, bit 1 is the synced value
    logic [1:0] ciaSelSync;
    logic [1:0] ciaClkSync;

    ////////////////////////////////////////////////////////////
    // Synchronizers
    ////////////////////////////////////////////////////////////

    // Select and CIA clock are both asynchronous to CLK80
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaSelSync <= 2'b00;
            ciaClkSync <= 2'b00;
        end else begin
            ciaSelSync <= {ciaSelSync[0], ciaSel};
            ciaClkSync <= {ciaClkSync[0], ciaClk};
        end
    end

    ////////////////////////////////////////////////////////////
    // Termination FSM
    ////////////////////////////////////////////////////////////

    // CIA cycles end at or just after the CIA clock falling edge
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaState <= CIA_IDLE;
            ciaReq <= 1'b0;
        end else begin
            ciaReq <= 1'b0;
            case (ciaState)
                CIA_IDLE: begin
                    // Wait for chip select
                    if (ciaSelSync[1]) begin
                        ciaState <= CIA_WAIT_HIGH;
                    end
                end
                CIA_WAIT_HIGH: begin
                    // Need a full high phase first
                    if (ciaClkSync[1]) begin
                        ciaState <= CIA_WAIT_FALL;
                    end
                end
                CIA_WAIT_FALL: begin
                    // Falling edge seen, align to low clk40 phase
                    if (!ciaClkSync[1] && !clk40) begin
                        ciaReq <= 1'b1;
                        ciaState <= CIA_WAIT_DESEL;
                    end
                end
                CIA_WAIT_DESEL: begin
                    // One request per select
                    if (!ciaSelSync[1]) begin
                        ciaState <= CIA_IDLE;
                    end
                end
                default: begin
                    ciaState <= CIA_IDLE;
                end
            endcase
        end
    end

    // Single pulse per CIA access
    ciaReqOneClock: assert property (
        @(posedge CLK80) disable iff (DELAYED_TACK_RST)
        ciaReq |=> !ciaReq
    ) else $error("ciaReq held longer than one clock");

endmodule

// ==== verilog/busTimeout.sv ====
`timescale 1ns/1ps

module busTimeout (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic clk40,
    input  logic tsN,
    input  logic agnusSpace,
    input  logic tackActive,
    output logic timeoutReq
);

    import tackPkg::*;

    // Any transfer start
    logic transferStart;
    // Clocks since the start, zero when idle
    logic [TIMEOUT_WIDTH-1:0] timeoutCnt;
    // Cycle ended or handed to the chipset
    logic timeoutClear;

    assign transferStart = !tsN && clk40;

    // Chipset terminates its own cycles
    assign timeoutClear = tackActive || agnusSpace;

    ////////////////////////////////////////////////////////////
    // Unclaimed cycle timer
    ////////////////////////////////////////////////////////////

    // Longest claimed cycle is a CIA access, about 1us
    // Wait a bit longer than that and end the cycle here
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            timeoutCnt <= '0;
            timeoutReq <= 1'b0;
        end else begin
            timeoutReq <= 1'b0;
            if (timeoutClear) begin
                // Some decoder answered
                timeoutCnt <= '0;
            end else if (timeoutCnt == '0) begin
                if (transferStart) begin
                    timeoutCnt <= timeoutCnt + 1'b1;
                end
            end else if (timeoutCnt == TIMEOUT_LAST) begin
                // Nobody claimed it
                timeoutReq <= 1'b1;
                timeoutCnt <= '0;
            end else begin
                timeoutCnt <= timeoutCnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/ackSequencer.sv ====
`timescale 1ns/1ps

module ackSequencer (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic clk40,
    input  logic tsN,
    input  logic autoVector,
    input  logic rtcEnN,
    input  logic cacheSpace,
    input  logic romReq,
    input  logic ciaReq,
    input  logic timeoutReq,
    input  logic acTack,
    output logic tackOut,
    output logic tackOe,
    output logic tbiOut,
    output logic tbiOe,
    output logic tciOut,
    output logic tciOe,
    output logic tackActive
);

    import tackPkg::*;

    // Interrupt ack or RTC start
    logic avStart;
    // Autovector delay line, top bit is the request
    logic [AV_DELAY_CYCLES:0] avPipe;
    // Any termination source
    logic anyReq;
    // Idle, assert, assert, negate
    logic [SEQ_WIDTH-1:0] seqCnt;

    ////////////////////////////////////////////////////////////
    // Autovector and RTC path
    ////////////////////////////////////////////////////////////

    // Everything is autovectored, so no data to wait for
    assign avStart = !tsN && clk40 && (autoVector || !rtcEnN);

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            avPipe <= '0;
        end else begin
            avPipe <= {avPipe[AV_DELAY_CYCLES-1:0], avStart};
        end
    end

    assign anyReq = avPipe[AV_DELAY_CYCLES] || romReq || ciaReq || timeoutReq || acTack;

    ////////////////////////////////////////////////////////////
    // Termination sequence
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            seqCnt <= SEQ_IDLE;
            tackOe <= 1'b0;
            tackOut <= 1'b1;
        end else if (seqCnt == SEQ_IDLE) begin
            // Requests only count while idle
            if (anyReq) begin
                seqCnt <= seqCnt + 1'b1;
                tackOe <= 1'b1;
                tackOut <= 1'b0;
            end
        end else if (seqCnt == SEQ_NEGATE) begin
            // Line was driven high, now let go
            tackOe <= 1'b0;
            seqCnt <= SEQ_IDLE;
        end else begin
            // Drive high before release
            if (seqCnt == SEQ_LAST_ASSERT) begin
                tackOut <= 1'b1;
            end
            seqCnt <= seqCnt + 1'b1;
        end
    end

    // No bursts here, burst inhibit follows TA
    assign tbiOut = tackOut;
    assign tbiOe = tackOe;
    // Cache inhibit only outside cacheable space
    assign tciOut = tackOut;
    assign tciOe = tackOe && !cacheSpace;

    // Clears the bus timeout
    assign tackActive = tackOe && !tackOut;

    // Sequence starts only from idle
    seqStartFromIdle: assert property (
        @(posedge CLK80) disable iff (DELAYED_TACK_RST)
        $rose(tackOe) |-> ($past(seqCnt) == SEQ_IDLE)
    ) else $error("termination started outside idle");

endmodule

// ==== verilog/transferAckCtrl.sv ====
`timescale 1ns/1ps

module transferAckCtrl (
    input  logic       CLK80,
    input  logic       DELAYED_TACK_RST,
    input  logic       clk40,
    input  logic       tsN,
    input  logic       romSel,
    input  logic [1:0] romDelay,
    input  logic       autoVector,
    input  logic       rtcEnN,
    input  logic       ciaSel,
    input  logic       ciaClk,
    input  logic       agnusSpace,
    input  logic       cacheSpace,
    input  logic       acTack,
    output logic       tackOut,
    output logic       tbiOut,
    output logic       tciOut,
    output logic       tackOe,
    output logic       tbiOe,
    output logic       tciOe,
    output logic       romEnN
);

    // Termination requests
    logic romReq;
    logic ciaReq;
    logic timeoutReq;
    // TA low, back to the timeout
    logic tackActive;

    // ROM setup timer
    romAckTimer uRomAck (
        .CLK80(CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .clk40(clk40),
        .tsN(tsN),
        .romSel(romSel),
        .romDelay(romDelay),
        .romEnN(romEnN),
        .romReq(romReq)
    );

    // Slow peripheral
    ciaAck uCiaAck (
        .CLK80(CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .clk40(clk40),
        .ciaSel(ciaSel),
        .ciaClk(ciaClk),
        .ciaReq(ciaReq)
    );

    // Unclaimed cycles
    busTimeout uTimeout (
        .CLK80(CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .clk40(clk40),
        .tsN(tsN),
        .agnusSpace(agnusSpace),
        .tackActive(tackActive),
        .timeoutReq(timeoutReq)
    );

    // TA, TBI and TCI drive
    ackSequencer uSeq (
        .CLK80(CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .clk40(clk40),
        .tsN(tsN),
        .autoVector(autoVector),
        .rtcEnN(rtcEnN),
        .cacheSpace(cacheSpace),
        .romReq(romReq),
        .ciaReq(ciaReq),
        .timeoutReq(timeoutReq),
        .acTack(acTack),
        .tackOut(tackOut),
        .tackOe(tackOe),
        .tbiOut(tbiOut),
        .tbiOe(tbiOe),
        .tciOut(tciOut),
        .tciOe(tciOe),
        .tackActive(tackActive)
    );

endmodule

// ==== testbench/tbTransferAck.sv ====
`timescale 1ns/1ps

module tbTransferAck;

    import tackPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CLOCKS = 10;
    // Idle clocks between cycles, 1 up to this
    localparam int GAP_MAX = 16;
    // Half period of the slow CIA clock in CLK80 clocks
    localparam int CIA_HALF = 12;
    localparam int CHIPSET_WAIT = 300;
    localparam int ACK_WAIT_MAX = 12;

    ////////////////////////////////////////////////////////////
    // Watchdog budget
    ////////////////////////////////////////////////////////////

    // Worst case clocks per test
    localparam int ROM_TEST_CLOCKS = 4 * (11 + ROM_HOLD_CYCLES + ACK_WAIT_MAX + GAP_MAX + 4);
    localparam int VECTOR_TEST_CLOCKS = 2 * (ACK_WAIT_MAX + GAP_MAX + 4);
    localparam int CIA_TEST_CLOCKS = 7 * CIA_HALF + ACK_WAIT_MAX + GAP_MAX + 4;
    localparam int AUTOCONFIG_TEST_CLOCKS = ACK_WAIT_MAX + GAP_MAX + 8;
    localparam int TIMEOUT_TEST_CLOCKS = TIMEOUT_CYCLES + ACK_WAIT_MAX + GAP_MAX + 4;
    localparam int WATCHDOG_CLOCKS = RESET_CLOCKS + ROM_TEST_CLOCKS + VECTOR_TEST_CLOCKS
        + CIA_TEST_CLOCKS + AUTOCONFIG_TEST_CLOCKS + TIMEOUT_TEST_CLOCKS + CHIPSET_WAIT + 200;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_ROM,
        KIND_VECTOR,
        KIND_CIA,
        KIND_TIMEOUT
    } cycleKindT;

    // DUT inputs
    logic CLK80;
    logic DELAYED_TACK_RST;
    logic clk40;
    logic tsN;
    logic romSel;
    logic [1:0] romDelay;
    logic autoVector;
    logic rtcEnN;
    logic ciaSel;
    logic ciaClk;
    logic agnusSpace;
    logic cacheSpace;
    logic acTack;
    // DUT outputs
    logic tackOut;
    logic tbiOut;
    logic tciOut;
    logic tackOe;
    logic tbiOe;
    logic tciOe;
    logic romEnN;

    int seed;
    // Cycle under test, read by the monitor
    cycleKindT curKind;
    logic [1:0] curStrap;
    // Monitor state
    int seqCount;
    int seqPhase;
    int startAge;
    int expLatency;
    logic measuring;
    // Termination value the sequence should show now
    logic expTack;

    transferAckCtrl uut (
        .CLK80(CLK80),
        .DELAYED_TACK_RST(DELAYED_TACK_RST),
        .clk40(clk40),
        .tsN(tsN),
        .romSel(romSel),
        .romDelay(romDelay),
        .autoVector(autoVector),
        .rtcEnN(rtcEnN),
        .ciaSel(ciaSel),
        .ciaClk(ciaClk),
        .agnusSpace(agnusSpace),
        .cacheSpace(cacheSpace),
        .acTack(acTack),
        .tackOut(tackOut),
        .tbiOut(tbiOut),
        .tciOut(tciOut),
        .tackOe(tackOe),
        .tbiOe(tbiOe),
        .tciOe(tciOe),
        .romEnN(romEnN)
    );

    initial begin
        CLK80 = 1'b0;
        forever #(CLK_PERIOD / 2) CLK80 = ~CLK80;
    end

    // CPU clock phase, half of CLK80
    always @(posedge CLK80) begin
        clk40 <= !clk40;
    end

    ////////////////////////////////////////////////////////////
    // Reference and checks
    ////////////////////////////////////////////////////////////

    // Clocks from the qualified start to tackOut low
    function automatic int expectedAckLatency(input cycleKindT kind, input logic [1:0] strap);
        case (kind)
            // Strap 00 is 11 clocks, each step 3 faster, plus one into TA
            KIND_ROM:     return 11 - 3 * int'(strap) + 1;
            KIND_VECTOR:  return 3;
            KIND_TIMEOUT: return TIMEOUT_CYCLES + 1;
            // CIA follows its own clock, chipset cycles never end here
            default:      return -1;
        endcase
    endfunction

    task automatic endWithFailure();
        $display(">>> FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic failRun(input string reason);
        $display("Error: %s", reason);
        endWithFailure();
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            endWithFailure();
        end
    endtask

    // Outputs sampled at the falling edge, settled by then
    always @(negedge CLK80) begin
        if (DELAYED_TACK_RST) begin
            seqPhase = 0;
            measuring = 1'b0;
        end else begin
            // Shape of a termination, low for two clocks then high for one
            if (tackOe) begin
                if (seqPhase == 0) begin
                    seqCount = seqCount + 1;
                end
                seqPhase = seqPhase + 1;
                if (seqPhase > ACK_ASSERT_CYCLES + 1) begin
                    failRun("acknowledge enable held past the negate clock");
                end
                expTack = (seqPhase <= ACK_ASSERT_CYCLES) ? 1'b0 : 1'b1;
            end else begin
                if (seqPhase != 0) begin
                    checkValue("tackOe clocks", seqPhase, ACK_ASSERT_CYCLES + 1);
                    seqPhase = 0;
                end
                // Resting value
                expTack = 1'b1;
            end
            checkValue("tackOut", 32'(tackOut), 32'(expTack));
            // TBI and TCI carry the same termination
            checkValue("tbiOut", 32'(tbiOut), 32'(expTack));
            checkValue("tbiOe", 32'(tbiOe), 32'(tackOe));
            checkValue("tciOut", 32'(tciOut), 32'(expTack));
            // No cache inhibit in cacheable space
            checkValue("tciOe", 32'(tciOe), cacheSpace ? 0 : 32'(tackOe));
            // Latency count, zero at the qualifying edge
            if (measuring) begin
                startAge = startAge + 1;
                if (tackOe && !tackOut) begin
                    measuring = 1'b0;
                    if (expLatency >= 0) begin
                        checkValue("tackOut latency", startAge, expLatency);
                    end
                end
            end
            // Next edge qualifies
            if (!tsN && clk40) begin
                measuring = 1'b1;
                startAge = -1;
                expLatency = expectedAckLatency(curKind, curStrap);
            end
        end
    end

    initial begin
        #(WATCHDOG_CLOCKS * CLK_PERIOD);
        failRun("simulation ran past its time budget, a test is stuck");
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // TS low for one clock, sampled in the high clk40 phase
    task automatic startTransfer(input cycleKindT kind, input logic [1:0] strap);
        @(negedge CLK80);
        if (clk40) @(negedge CLK80);
        @(posedge CLK80);
        curKind = kind;
        curStrap = strap;
        tsN <= 1'b0;
        @(posedge CLK80);
        tsN <= 1'b1;
    endtask

    // Until one more termination has run to its end
    task automatic waitAckDone(input int seqBefore, input int maxClocks, input string what);
        int waited;
        waited = 0;
        do begin
            @(posedge CLK80);
            waited = waited + 1;
            if (waited > maxClocks) begin
                failRun({"no termination seen for the ", what, " cycle"});
            end
        end while (!(seqCount > seqBefore && seqPhase == 0));
    endtask

    task automatic idleGap();
        int gap;
        gap = 1 + ($unsigned($random(seed)) % GAP_MAX);
        repeat (gap) @(posedge CLK80);
    endtask

    task automatic runRomCycle(input logic [1:0] strap, input logic cache);
        int d;
        int k;
        int seqBefore;
        d = expectedAckLatency(KIND_ROM, strap) - 1;
        @(posedge CLK80);
        seqBefore = seqCount;
        romSel <= 1'b1;
        romDelay <= strap;
        cacheSpace <= cache;
        startTransfer(KIND_ROM, strap);
        // ROM enabled from edge 1, released at edge D+hold
        for (k = 0; k <= d + ROM_HOLD_CYCLES + 1; k++) begin
            @(negedge CLK80);
            checkValue("romEnN", 32'(romEnN), (k >= 1 && k < d + ROM_HOLD_CYCLES) ? 0 : 1);
        end
        waitAckDone(seqBefore, ACK_WAIT_MAX, "ROM");
        romSel <= 1'b0;
    endtask

    task automatic runVectorCycle(input logic useRtc);
        int seqBefore;
        @(posedge CLK80);
        seqBefore = seqCount;
        if (useRtc) begin
            rtcEnN <= 1'b0;
        end else begin
            autoVector <= 1'b1;
        end
        cacheSpace <= 1'b0;
        startTransfer(KIND_VECTOR, 2'b00);
        waitAckDone(seqBefore, ACK_WAIT_MAX, "autovector");
        autoVector <= 1'b0;
        rtcEnN <= 1'b1;
    endtask

    task automatic runCiaCycle();
        int seqBefore;
        @(posedge CLK80);
        seqBefore = seqCount;
        ciaSel <= 1'b1;
        ciaClk <= 1'b0;
        cacheSpace <= 1'b0;
        startTransfer(KIND_CIA, 2'b00);
        // One low and one high phase of the slow clock
        repeat (CIA_HALF) @(posedge CLK80);
        ciaClk <= 1'b1;
        repeat (CIA_HALF) @(posedge CLK80);
        checkValue("terminations before CIA clock fall", seqCount, seqBefore);
        ciaClk <= 1'b0;
        waitAckDone(seqBefore, ACK_WAIT_MAX, "CIA");
        // Another full period, select still held
        repeat (CIA_HALF) @(posedge CLK80);
        ciaClk <= 1'b1;
        repeat (CIA_HALF) @(posedge CLK80);
        ciaClk <= 1'b0;
        ciaSel <= 1'b0;
        // And one after deselect
        repeat (CIA_HALF) @(posedge CLK80);
        ciaClk <= 1'b1;
        repeat (CIA_HALF) @(posedge CLK80);
        ciaClk <= 1'b0;
        repeat (CIA_HALF) @(posedge CLK80);
        checkValue("CIA terminations", seqCount, seqBefore + 1);
    endtask

    // Autoconfig board answers with a one clock pulse
    task automatic runAutoconfigCycle();
        int seqBefore;
        @(posedge CLK80);
        seqBefore = seqCount;
        cacheSpace <= 1'b0;
        startTransfer(KIND_NONE, 2'b00);
        @(posedge CLK80);
        acTack <= 1'b1;
        @(posedge CLK80);
        acTack <= 1'b0;
        // TA driven low from the edge that saw the pulse
        @(negedge CLK80);
        checkValue("tackOe after acTack", 32'(tackOe), 1);
        checkValue("tackOut after acTack", 32'(tackOut), 0);
        waitAckDone(seqBefore, ACK_WAIT_MAX, "autoconfig");
    endtask

    task automatic runUnclaimedCycle(input logic chipset);
        int seqBefore;
        @(posedge CLK80);
        seqBefore = seqCount;
        agnusSpace <= chipset;
        cacheSpace <= 1'b1;
        if (chipset) begin
            startTransfer(KIND_NONE, 2'b00);
            repeat (CHIPSET_WAIT) @(posedge CLK80);
            checkValue("terminations in chipset space", seqCount, seqBefore);
        end else begin
            startTransfer(KIND_TIMEOUT, 2'b00);
            waitAckDone(seqBefore, TIMEOUT_CYCLES + ACK_WAIT_MAX, "unclaimed");
        end
        agnusSpace <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [1:0] straps[4];
        logic [1:0] tmpStrap;
        int i;
        int j;
        seed = 12355;
        seqCount = 0;
        seqPhase = 0;
        measuring = 1'b0;
        expTack = 1'b1;
        curKind = KIND_NONE;
        curStrap = 2'b00;
        DELAYED_TACK_RST = 1'b1;
        clk40 = 1'b0;
        tsN = 1'b1;
        romSel = 1'b0;
        romDelay = 2'b00;
        autoVector = 1'b0;
        rtcEnN = 1'b1;
        ciaSel = 1'b0;
        ciaClk = 1'b0;
        agnusSpace = 1'b0;
        cacheSpace = 1'b0;
        acTack = 1'b0;
        repeat (RESET_CLOCKS) @(posedge CLK80);
        DELAYED_TACK_RST <= 1'b0;
        @(negedge CLK80);
        // Quiet bus out of reset
        checkValue("tackOe", 32'(tackOe), 0);
        checkValue("tbiOe", 32'(tbiOe), 0);
        checkValue("tciOe", 32'(tciOe), 0);
        checkValue("romEnN", 32'(romEnN), 1);
        // All four straps, shuffled
        for (i = 0; i < 4; i++) begin
            straps[i] = 2'(i);
        end
        for (i = 3; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmpStrap = straps[i];
            straps[i] = straps[j];
            straps[j] = tmpStrap;
        end
        for (i = 0; i < 4; i++) begin
            runRomCycle(straps[i], 1'(i % 2));
            idleGap();
        end
        runVectorCycle(1'b0);
        idleGap();
        runVectorCycle(1'b1);
        idleGap();
        runCiaCycle();
        idleGap();
        runAutoconfigCycle();
        idleGap();
        runUnclaimedCycle(1'b0);
        idleGap();
        runUnclaimedCycle(1'b1);
        // 4 ROM, 2 vector, 1 CIA, 1 autoconfig, 1 timeout
        checkValue("total terminations", seqCount, 9);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/tackPkg.sv
verilog/romAckTimer.sv
verilog/ciaAck.sv
verilog/busTimeout.sv
verilog/ackSequencer.sv
verilog/transferAckCtrl.sv
testbench/tbTransferAck.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the transfer acknowledge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=simTransferAck
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f project.f \
    --top-module tbTransferAck \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG_FILE"; then
    echo "Result: testbench passed"
    exit 0
else
    echo "Result: testbench did not pass"
    exit 1
fi
